/* rtl/fabric_config.svh */
`ifndef FABRIC_CONFIG_SVH
`define FABRIC_CONFIG_SVH

// Upper address byte that selects the fabric
`define FABRIC_BASE 8'h30

// Fabric geometry
`define CLB_ROWS    4
`define NUM_GPIO    8
`define NUM_REGIONS 3

// Datapath widths
`define CFG_WORD_W  32
`define ACC_W       32
`define COEF_W      8

// Region ids, address bits 9:8
`define REGION_MAC  2'd2

// Word offsets within a region, address bits 3:2
`define REG_SHIFT   2'd0
`define REG_CTRL    2'd1
`define REG_ACC     2'd2

`endif

/* rtl/fabric_pkg.sv */
`include "fabric_config.svh"

package fabric_pkg;

  // One LUT4 tile configuration word, high bits first
  typedef struct packed {
    logic [15:0] lut_mask;
    logic [2:0]  sel0;
    logic [2:0]  sel1;
    logic [2:0]  sel2;
    logic [2:0]  sel3;
    logic        use_ff;
    logic [2:0]  pad;
  } clb_cfg_t;

  // Row 0 is the oldest word in the chain
  typedef clb_cfg_t [`CLB_ROWS-1:0] clb_col_cfg_t;

  typedef enum logic [1:0] {
    MAC_HOLD  = 2'd0,
    MAC_ACC   = 2'd1,
    MAC_LOAD  = 2'd2,
    MAC_CLEAR = 2'd3
  } mac_mode_e;

  typedef struct packed {
    mac_mode_e                     mode;
    logic                          is_signed;
    logic [`COEF_W-1:0]            coef;
    logic [`CFG_WORD_W-4-`COEF_W:0] pad;
  } mac_cfg_t;

  typedef struct packed {
    logic [`CFG_WORD_W-3:0] pad;
    logic                   gpio_oe;
    logic                   fabric_en;
  } fabric_ctrl_t;

  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic [1:0]             region;
    logic [1:0]             offset;
    logic [`CFG_WORD_W-1:0] wdata;
  } cfg_req_t;

endpackage

/* rtl/wb_config_decoder.sv */
`timescale 1ns/1ps
`include "fabric_config.svh"

module wb_config_decoder (
  input  logic                                    wb_clk_i,
  input  logic                                    rst_n_i,
  input  logic                                    wbs_stb_i,
  input  logic                                    wbs_cyc_i,
  input  logic                                    wbs_we_i,
  input  logic [3:0]                              wbs_sel_i,
  input  logic [31:0]                             wbs_addr_i,
  input  logic [31:0]                             wbs_data_i,
  output logic                                    wbs_ack_o,
  output logic [31:0]                             wbs_data_o,
  input  logic [`NUM_REGIONS-1:0][`CFG_WORD_W-1:0] tail_words_i,
  input  logic [`ACC_W-1:0]                       acc_i,
  output logic [`NUM_REGIONS-1:0]                 shift_o,
  output logic [`CFG_WORD_W-1:0]                  shift_data_o,
  output fabric_pkg::fabric_ctrl_t                ctrl_o
);
  import fabric_pkg::*;

  cfg_req_t                req;
  fabric_ctrl_t            ctrl_q;
  logic                    hit;
  logic                    region_ok;
  logic [`CFG_WORD_W-1:0]  rdata;

  // New request only while no ack is outstanding
  always_comb begin
    req.valid  = wbs_stb_i && wbs_cyc_i && !wbs_ack_o;
    req.we     = wbs_we_i;
    req.region = wbs_addr_i[9:8];
    req.offset = wbs_addr_i[3:2];
    req.wdata  = wbs_data_i;
  end

  // Byte lanes are not decoded, every access is a full word
  assign hit       = (wbs_addr_i[31:24] == `FABRIC_BASE);
  assign region_ok = (req.region < 2'(`NUM_REGIONS));

  // One strobe per region, only on the accepting cycle
  always_comb begin
    shift_o = '0;
    if (req.valid && req.we && hit && region_ok && req.offset == `REG_SHIFT) begin
      shift_o[req.region] = 1'b1;
    end
  end

  assign shift_data_o = req.wdata;

  // Readback mux
  always_comb begin
    rdata = '0;
    if (hit) begin
      case (req.offset)
        `REG_SHIFT: begin
          if (region_ok) begin
            rdata = tail_words_i[req.region];
          end
        end
        `REG_CTRL: rdata = ctrl_q;
        `REG_ACC: begin
          if (req.region == `REGION_MAC) begin
            rdata = acc_i;
          end
        end
        default: rdata = '0;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      wbs_ack_o  <= 1'b0;
      wbs_data_o <= '0;
      ctrl_q     <= '0;
    end else begin
      wbs_ack_o  <= req.valid;
      wbs_data_o <= (req.valid && !req.we) ? rdata : '0;
      // Control register is shared by all regions
      if (req.valid && req.we && hit && req.offset == `REG_CTRL) begin
        ctrl_q.fabric_en <= req.wdata[0];
        ctrl_q.gpio_oe   <= req.wdata[1];
      end
    end
  end

  assign ctrl_o = ctrl_q;

  // Single-cycle ack per access
  a_ack_pulse: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    wbs_ack_o |=> !wbs_ack_o)
    else $error("wbs_ack_o held for two cycles");

endmodule

/* rtl/config_shift_chain.sv */
`timescale 1ns/1ps
`include "fabric_config.svh"

module config_shift_chain #(
  parameter type cfg_t = logic [`CFG_WORD_W-1:0]
) (
  input  logic                   wb_clk_i,
  input  logic                   rst_n_i,
  input  logic                   shift_i,
  input  logic [`CFG_WORD_W-1:0] data_i,
  output cfg_t                   cfg_o,
  output logic [`CFG_WORD_W-1:0] tail_o
);

  localparam int NUM_WORDS = $bits(cfg_t) / `CFG_WORD_W;
  localparam int CHAIN_W   = NUM_WORDS * `CFG_WORD_W;

  logic [NUM_WORDS-1:0][`CFG_WORD_W-1:0] words_q;
  logic [CHAIN_W+`CFG_WORD_W-1:0]        chain_cat;

  // Head is the top slot, slot 0 is the tail
  assign chain_cat = {data_i, words_q};

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      words_q <= '0;
    end else if (shift_i) begin
      words_q <= chain_cat[CHAIN_W+`CFG_WORD_W-1:`CFG_WORD_W];
    end
  end

  assign cfg_o  = cfg_t'(words_q);
  assign tail_o = words_q[0];

  a_word_multiple: assert property (@(posedge wb_clk_i)
    ($bits(cfg_t) % `CFG_WORD_W) == 0)
    else $error("config type is not a whole number of words");

endmodule

/* rtl/clb_tile.sv */
`timescale 1ns/1ps

module clb_tile (
  input  logic                 wb_clk_i,
  input  logic                 rst_n_i,
  input  logic                 en_i,
  input  logic [7:0]           src_i,
  input  fabric_pkg::clb_cfg_t cfg_i,
  output logic                 out_o
);

  logic [3:0] lut_idx;
  logic       lut_out;
  logic       ff_q;

  // Per-input source selects, sel0 drives the index LSB
  assign lut_idx = {src_i[cfg_i.sel3],
                    src_i[cfg_i.sel2],
                    src_i[cfg_i.sel1],
                    src_i[cfg_i.sel0]};

  assign lut_out = cfg_i.lut_mask[lut_idx];

  // Optional register stage, frozen while the fabric is disabled
  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      ff_q <= 1'b0;
    end else if (en_i) begin
      ff_q <= lut_out;
    end
  end

  assign out_o = cfg_i.use_ff ? ff_q : lut_out;

endmodule

/* rtl/clb_column.sv */
`timescale 1ns/1ps
`include "fabric_config.svh"

module clb_column (
  input  logic                     wb_clk_i,
  input  logic                     rst_n_i,
  input  logic                     en_i,
  input  logic [7:0]               src_i,
  input  fabric_pkg::clb_col_cfg_t cfg_i,
  output logic [`CLB_ROWS-1:0]     out_o
);

  // Each row takes its own word out of the column config
  for (genvar r = 0; r < `CLB_ROWS; r++) begin : g_row
    clb_tile u_clb_tile (
      .wb_clk_i (wb_clk_i),
      .rst_n_i  (rst_n_i),
      .en_i     (en_i),
      .src_i    (src_i),
      .cfg_i    (cfg_i[r]),
      .out_o    (out_o[r])
    );
  end

  // Sources and config are reset or driven, so outputs stay known
  a_no_x_out: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    !$isunknown(out_o))
    else $error("clb_column output has X");

endmodule

/* rtl/mac_tile.sv */
`timescale 1ns/1ps
`include "fabric_config.svh"

module mac_tile (
  input  logic                 wb_clk_i,
  input  logic                 rst_n_i,
  input  logic                 en_i,
  input  logic [7:0]           a_i,
  input  fabric_pkg::mac_cfg_t cfg_i,
  output logic [`ACC_W-1:0]    acc_o
);
  import fabric_pkg::*;

  logic [15:0]       prod;
  logic [`ACC_W-1:0] prod_ext;
  logic [`ACC_W-1:0] acc_q;

  // 8x8 product, signedness from config
  always_comb begin
    if (cfg_i.is_signed) begin
      prod = $signed(a_i) * $signed(cfg_i.coef);
    end else begin
      prod = a_i * cfg_i.coef;
    end
  end

  assign prod_ext = cfg_i.is_signed ? {{(`ACC_W-16){prod[15]}}, prod}
                                    : {{(`ACC_W-16){1'b0}}, prod};

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      acc_q <= '0;
    end else if (cfg_i.mode == MAC_CLEAR) begin
      // Clear works even with the fabric stopped
      acc_q <= '0;
    end else if (en_i) begin
      case (cfg_i.mode)
        MAC_ACC:  acc_q <= acc_q + prod_ext;
        MAC_LOAD: acc_q <= prod_ext;
        default:  acc_q <= acc_q;
      endcase
    end
  end

  assign acc_o = acc_q;

endmodule

/* rtl/gpio_result_stage.sv */
`timescale 1ns/1ps
`include "fabric_config.svh"

module gpio_result_stage (
  input  logic                 wb_clk_i,
  input  logic                 rst_n_i,
  input  logic [3:0]           clb_i,
  input  logic [3:0]           mac_i,
  input  logic                 oe_en_i,
  output logic [`NUM_GPIO-1:0] gpio_out_o,
  output logic [`NUM_GPIO-1:0] gpio_oe_o
);

  // Pins see only registered values
  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      gpio_out_o <= '0;
      gpio_oe_o  <= '0;
    end else begin
      gpio_out_o <= {mac_i, clb_i};
      gpio_oe_o  <= {`NUM_GPIO{oe_en_i}};
    end
  end

endmodule

/* rtl/fpga_fabric_top.sv */
`timescale 1ns/1ps
`include "fabric_config.svh"

module fpga_fabric_top (
  input  logic                 wb_clk_i,
  input  logic                 rst_n_i,
  input  logic                 wbs_stb_i,
  input  logic                 wbs_cyc_i,
  input  logic                 wbs_we_i,
  input  logic [3:0]           wbs_sel_i,
  input  logic [31:0]          wbs_addr_i,
  input  logic [31:0]          wbs_data_i,
  output logic                 wbs_ack_o,
  output logic [31:0]          wbs_data_o,
  input  logic [`NUM_GPIO-1:0] gpio_in_i,
  output logic [`NUM_GPIO-1:0] gpio_out_o,
  output logic [`NUM_GPIO-1:0] gpio_oe_o
);
  import fabric_pkg::*;

  logic [`NUM_REGIONS-1:0]                  shift;
  logic [`CFG_WORD_W-1:0]                   shift_data;
  logic [`NUM_REGIONS-1:0][`CFG_WORD_W-1:0] tail_words;
  fabric_ctrl_t                             ctrl;
  clb_col_cfg_t                             col0_cfg;
  clb_col_cfg_t                             col1_cfg;
  mac_cfg_t                                 mac_cfg;
  logic [`CLB_ROWS-1:0]                     col0_out;
  logic [`CLB_ROWS-1:0]                     col1_out;
  logic [`ACC_W-1:0]                        acc;

  wb_config_decoder u_wb_config_decoder (
    .wb_clk_i     (wb_clk_i),
    .rst_n_i      (rst_n_i),
    .wbs_stb_i    (wbs_stb_i),
    .wbs_cyc_i    (wbs_cyc_i),
    .wbs_we_i     (wbs_we_i),
    .wbs_sel_i    (wbs_sel_i),
    .wbs_addr_i   (wbs_addr_i),
    .wbs_data_i   (wbs_data_i),
    .wbs_ack_o    (wbs_ack_o),
    .wbs_data_o   (wbs_data_o),
    .tail_words_i (tail_words),
    .acc_i        (acc),
    .shift_o      (shift),
    .shift_data_o (shift_data),
    .ctrl_o       (ctrl)
  );

  config_shift_chain #(.cfg_t(clb_col_cfg_t)) u_chain_col0 (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .shift_i  (shift[0]),
    .data_i   (shift_data),
    .cfg_o    (col0_cfg),
    .tail_o   (tail_words[0])
  );

  config_shift_chain #(.cfg_t(clb_col_cfg_t)) u_chain_col1 (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .shift_i  (shift[1]),
    .data_i   (shift_data),
    .cfg_o    (col1_cfg),
    .tail_o   (tail_words[1])
  );

  config_shift_chain #(.cfg_t(mac_cfg_t)) u_chain_mac (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .shift_i  (shift[2]),
    .data_i   (shift_data),
    .cfg_o    (mac_cfg),
    .tail_o   (tail_words[2])
  );

  // Column 0 sees only the pins
  clb_column u_clb_column0 (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .en_i     (ctrl.fabric_en),
    .src_i    (gpio_in_i),
    .cfg_i    (col0_cfg),
    .out_o    (col0_out)
  );

  // Column 1 feeds forward from column 0, no loops
  clb_column u_clb_column1 (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .en_i     (ctrl.fabric_en),
    .src_i    ({gpio_in_i[3:0], col0_out}),
    .cfg_i    (col1_cfg),
    .out_o    (col1_out)
  );

  mac_tile u_mac_tile (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .en_i     (ctrl.fabric_en),
    .a_i      (gpio_in_i),
    .cfg_i    (mac_cfg),
    .acc_o    (acc)
  );

  gpio_result_stage u_gpio_result_stage (
    .wb_clk_i   (wb_clk_i),
    .rst_n_i    (rst_n_i),
    .clb_i      (col1_out),
    .mac_i      (acc[3:0]),
    .oe_en_i    (ctrl.gpio_oe),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o)
  );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 4,
  parameter int RST_CYCLES     = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Release just after a rising edge, like every other input
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

/* verif/fabric_tb.sv */
`timescale 1ns/1ps
`include "fabric_config.svh"

module fabric_tb;
  import fabric_pkg::*;

  localparam int NUM_ACCESSES    = 32;
  localparam int WATCHDOG_CYCLES = NUM_ACCESSES * 40 + 200;
  localparam int ACK_LIMIT       = 8;
  localparam int NUM_VECTORS     = 16;

  logic         clk;
  logic         rst_n;
  logic         wbs_stb;
  logic         wbs_cyc;
  logic         wbs_we;
  logic [3:0]   wbs_sel;
  logic [31:0]  wbs_addr;
  logic [31:0]  wbs_wdata;
  logic         wbs_ack;
  logic [31:0]  wbs_rdata;
  logic [7:0]   gpio_in;
  logic [7:0]   gpio_out;
  logic [7:0]   gpio_oe;
  logic [31:0]  lfsr_q = 32'h9759_7196;
  int           value_errs = 0;
  int           protocol_errs = 0;
  logic         chk_comb;
  logic         chk_ff;
  logic         chk_hold;
  clb_col_cfg_t col0_m;
  clb_col_cfg_t col1_m;
  logic [3:0]   model_out;
  logic [31:0]  hist[$];
  logic [31:0]  rd;
  logic [31:0]  acc_exp;
  logic [7:0]   coef;
  logic [7:0]   a_val;
  logic         mac_sgn;

  tb_clock_gen u_tb_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

  fpga_fabric_top u_fpga_fabric_top (
    .wb_clk_i   (clk),
    .rst_n_i    (rst_n),
    .wbs_stb_i  (wbs_stb),
    .wbs_cyc_i  (wbs_cyc),
    .wbs_we_i   (wbs_we),
    .wbs_sel_i  (wbs_sel),
    .wbs_addr_i (wbs_addr),
    .wbs_data_i (wbs_wdata),
    .wbs_ack_o  (wbs_ack),
    .wbs_data_o (wbs_rdata),
    .gpio_in_i  (gpio_in),
    .gpio_out_o (gpio_out),
    .gpio_oe_o  (gpio_oe)
  );

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] fab_addr(input logic [1:0] region, input logic [1:0] offset);
    return {`FABRIC_BASE, 14'd0, region, 4'd0, offset, 2'd0};
  endfunction

  // Reference LUT column with sel0 as the index LSB
  function automatic logic [3:0] col_eval(input clb_col_cfg_t cc, input logic [7:0] src);
    logic [3:0] res;
    logic [3:0] idx;
    for (int r = 0; r < `CLB_ROWS; r++) begin
      idx    = {src[cc[r].sel3], src[cc[r].sel2], src[cc[r].sel1], src[cc[r].sel0]};
      res[r] = cc[r].lut_mask[idx];
    end
    return res;
  endfunction

  function automatic logic [31:0] mac_product(input logic [7:0] a, input logic [7:0] c,
                                              input logic sgn);
    int sa;
    int sc;
    sa = sgn ? int'($signed(a)) : int'({24'd0, a});
    sc = sgn ? int'($signed(c)) : int'({24'd0, c});
    return 32'(sa * sc);
  endfunction

  function automatic logic [31:0] mac_word(input mac_mode_e mode, input logic sgn,
                                           input logic [7:0] c);
    mac_cfg_t m;
    m = '{mode: mode, is_signed: sgn, coef: c, pad: '0};
    return m;
  endfunction

  // Column 1 sees column 0 outputs low and pins 3:0 high
  always_comb begin
    model_out = col_eval(col1_m, {gpio_in[3:0], col_eval(col0_m, gpio_in)});
  end

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      value_errs++;
      $display("FAILED t=%0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic bus_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    wbs_stb   = 1'b1;
    wbs_cyc   = 1'b1;
    wbs_we    = write;
    wbs_addr  = addr;
    wbs_wdata = wdata;
    wait_cycles(1);
    waited = 1;
    while (!wbs_ack && waited < ACK_LIMIT) begin
      wait_cycles(1);
      waited++;
    end
    if (!wbs_ack) begin
      protocol_errs++;
      $display("No ack came back for the access to %h", addr);
    end else if (waited != 1) begin
      protocol_errs++;
      $display("Ack for %h came %0d cycles after the strobe", addr, waited);
    end
    rdata   = wbs_rdata;
    wbs_stb = 1'b0;
    wbs_cyc = 1'b0;
    wbs_we  = 1'b0;
    wait_cycles(1);
  endtask

  task automatic set_ctrl(input logic en, input logic oe);
    bus_access(1'b1, fab_addr(2'd0, `REG_CTRL), {30'd0, oe, en}, rd);
    check_word({24'd0, gpio_oe}, {24'd0, {8{oe}}}, "gpio_oe_o");
  endtask

  // Row 0 goes in first and ends up at the chain tail
  task automatic config_column(input logic [1:0] region, input logic use_ff,
                               output clb_col_cfg_t cc);
    clb_cfg_t word;
    for (int r = 0; r < `CLB_ROWS; r++) begin
      word = '{lut_mask: 16'(next_bits(16)), sel0: 3'(next_bits(3)), sel1: 3'(next_bits(3)),
               sel2: 3'(next_bits(3)), sel3: 3'(next_bits(3)), use_ff: use_ff, pad: '0};
      bus_access(1'b1, fab_addr(region, `REG_SHIFT), word, rd);
      cc[r] = word;
    end
  endtask

  task automatic drive_random_inputs(input int n);
    repeat (n) begin
      gpio_in = 8'(next_bits(8));
      wait_cycles(1);
    end
  endtask

  a_ack_next: assert property (@(posedge clk) disable iff (!rst_n)
    (wbs_stb && wbs_cyc && !wbs_ack) |=> wbs_ack)
    else begin
      protocol_errs++;
      $display("Ack did not follow an accepted strobe at %0t", $time);
    end

  a_ack_once: assert property (@(posedge clk) disable iff (!rst_n) wbs_ack |=> !wbs_ack)
    else begin
      protocol_errs++;
      $display("Ack stayed high for two cycles at %0t", $time);
    end

  a_lut_comb: assert property (@(posedge clk) disable iff (!rst_n)
    chk_comb |-> gpio_out[3:0] == $past(model_out))
    else begin
      value_errs++;
      $display("FAILED t=%0t: combinational LUT output %h", $time, gpio_out[3:0]);
    end

  a_lut_ff: assert property (@(posedge clk) disable iff (!rst_n)
    chk_ff |-> gpio_out[3:0] == $past(model_out, 2))
    else begin
      value_errs++;
      $display("FAILED t=%0t: registered LUT output %h", $time, gpio_out[3:0]);
    end

  a_ff_hold: assert property (@(posedge clk) disable iff (!rst_n)
    chk_hold |-> $stable(gpio_out[3:0]))
    else begin
      value_errs++;
      $display("FAILED t=%0t: registered output moved while disabled", $time);
    end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    wbs_stb   = 1'b0;
    wbs_cyc   = 1'b0;
    wbs_we    = 1'b0;
    wbs_sel   = 4'hf;
    wbs_addr  = '0;
    wbs_wdata = '0;
    gpio_in   = '0;
    chk_comb  = 1'b0;
    chk_ff    = 1'b0;
    chk_hold  = 1'b0;
    col0_m    = '0;
    col1_m    = '0;
    @(posedge rst_n);
    wait_cycles(1);

    // Reset state
    check_word({16'd0, gpio_oe, gpio_out}, 32'd0, "GPIO pins after reset");
    bus_access(1'b0, fab_addr(2'd0, `REG_CTRL), '0, rd);
    check_word(rd, 32'd0, "control register after reset");

    // Chain depth through tail readback
    repeat (5) begin
      hist.push_back(next_bits(32));
      bus_access(1'b1, fab_addr(2'd0, `REG_SHIFT), hist[hist.size() - 1], rd);
    end
    bus_access(1'b0, fab_addr(2'd0, `REG_SHIFT), '0, rd);
    check_word(rd, hist[hist.size() - `CLB_ROWS], "column 0 tail word");
    repeat (2) begin
      hist.push_back(next_bits(32));
      bus_access(1'b1, fab_addr(`REGION_MAC, `REG_SHIFT), hist[hist.size() - 1], rd);
    end
    bus_access(1'b0, fab_addr(`REGION_MAC, `REG_SHIFT), '0, rd);
    check_word(rd, hist[hist.size() - 1], "MAC config word");

    // Combinational LUTs in both columns
    config_column(2'd0, 1'b0, col0_m);
    config_column(2'd1, 1'b0, col1_m);
    set_ctrl(1'b1, 1'b1);

    // Address decode while every region and the control register hold data
    // Upper byte one above the fabric base
    bus_access(1'b0, fab_addr(2'd0, `REG_CTRL) ^ 32'h0100_0000, '0, rd);
    check_word(rd, 32'd0, "read outside the fabric");
    bus_access(1'b0, fab_addr(2'd3, `REG_SHIFT), '0, rd);
    check_word(rd, 32'd0, "read of unused region");

    wait_cycles(2);
    chk_comb = 1'b1;
    drive_random_inputs(2 * NUM_VECTORS);
    chk_comb = 1'b0;

    // Registered column 1, then frozen by fabric_en
    config_column(2'd1, 1'b1, col1_m);
    wait_cycles(3);
    chk_ff = 1'b1;
    drive_random_inputs(NUM_VECTORS);
    chk_ff = 1'b0;
    set_ctrl(1'b0, 1'b1);
    wait_cycles(1);
    chk_hold = 1'b1;
    drive_random_inputs(NUM_VECTORS);
    chk_hold = 1'b0;

    // Zero input keeps bus cycles out of the MAC sum
    gpio_in = '0;
    mac_sgn = next_bits(1) & 1'b1;
    coef    = 8'(next_bits(8));
    bus_access(1'b1, fab_addr(`REGION_MAC, `REG_SHIFT), mac_word(MAC_CLEAR, 1'b0, '0), rd);
    bus_access(1'b1, fab_addr(`REGION_MAC, `REG_SHIFT), mac_word(MAC_ACC, mac_sgn, coef), rd);
    set_ctrl(1'b1, 1'b1);
    acc_exp = '0;
    repeat (NUM_VECTORS) begin
      a_val   = 8'(next_bits(8));
      gpio_in = a_val;
      acc_exp = acc_exp + mac_product(a_val, coef, mac_sgn);
      wait_cycles(1);
    end
    gpio_in = '0;
    bus_access(1'b0, fab_addr(`REGION_MAC, `REG_ACC), '0, rd);
    check_word(rd, acc_exp, "accumulator readback");
    check_word({28'd0, gpio_out[7:4]}, {28'd0, acc_exp[3:0]}, "gpio_out_o[7:4]");
    bus_access(1'b1, fab_addr(`REGION_MAC, `REG_SHIFT), mac_word(MAC_CLEAR, 1'b0, '0), rd);
    bus_access(1'b0, fab_addr(`REGION_MAC, `REG_ACC), '0, rd);
    check_word(rd, 32'd0, "accumulator after clear");

    $display("Error counts: %0d value, %0d protocol", value_errs, protocol_errs);
    if (value_errs == 0 && protocol_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+rtl
rtl/fabric_pkg.sv
rtl/wb_config_decoder.sv
rtl/config_shift_chain.sv
rtl/clb_tile.sv
rtl/clb_column.sv
rtl/mac_tile.sv
rtl/gpio_result_stage.sv
rtl/fpga_fabric_top.sv
verif/tb_clock_gen.sv
verif/fabric_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the fabric testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module fabric_tb -f src.f -o fabric_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/fabric_sim > "$LOG" 2>&1
cat "$LOG"

grep -q "RESULT: FAIL" "$LOG" && { echo "Simulation reported failure"; exit 1; }
grep -q "RESULT: PASS" "$LOG" || { echo "No result line in $LOG"; exit 1; }
exit 0
